// ==== conc_cfg_pkg.sv ====
// sizes of the message concentrator
// NUM_CHAN must stay a power of two for the round-robin order to hold
// LANE_DEPTH need not be a power of two since the pointers wrap explicitly

package conc_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // base sizes
  ////////////////////////////////////////////////////////////////////////////

  // number of input channels and lanes
  localparam int unsigned NUM_CHAN = 4;

  // words held by each lane FIFO
  localparam int unsigned LANE_DEPTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // derived widths
  ////////////////////////////////////////////////////////////////////////////

  // bits needed to name one channel
  localparam int unsigned CHAN_W = $clog2(NUM_CHAN);
  // fill count has to reach LANE_DEPTH itself
  localparam int unsigned CNT_W = $clog2(LANE_DEPTH + 1);
  // read and write pointer width inside a lane
  localparam int unsigned PTR_W = $clog2(LANE_DEPTH);

endpackage : conc_cfg_pkg

// ==== conc_msg_pkg.sv ====
// message types carried through the concentrator
// channel index and fill count widths follow conc_cfg_pkg

package conc_msg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////////////////////

  // payload bits per message
  localparam int unsigned PAYLOAD_W = 16;

  // one message payload as stored in a lane
  typedef logic [PAYLOAD_W-1:0] payload_t;

  ////////////////////////////////////////////////////////////////////////////
  // indices and counts
  ////////////////////////////////////////////////////////////////////////////

  // channel number on input and output
  typedef logic [conc_cfg_pkg::CHAN_W-1:0] chan_idx_t;

  // lane occupancy from 0 to LANE_DEPTH
  typedef logic [conc_cfg_pkg::CNT_W-1:0] fill_cnt_t;

endpackage : conc_msg_pkg

// ==== ingress_steer.sv ====
// registers one input word per cycle and steers it to its lane
// no full check here since each lane decides alone whether to drop
// a word sampled together with flush_i is discarded

`timescale 1ns/1ps

module ingress_steer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    in_valid_i,
  input  conc_msg_pkg::chan_idx_t in_chan_i,
  input  conc_msg_pkg::payload_t  in_data_i,
  lane_if.steer                   lanes [conc_cfg_pkg::NUM_CHAN]
);
  import conc_cfg_pkg::*;
  import conc_msg_pkg::*;

  // registered strobe, channel and payload
  logic      valid_q;
  chan_idx_t chan_q;
  payload_t  data_q;

  // strobe is control state and is cleared by flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid_i;
    end
  end

  // channel and payload only matter while valid_q is high
  always_ff @(posedge clk_i) begin
    chan_q <= in_chan_i;
    data_q <= in_data_i;
  end

  // decode the registered channel into exactly one push
  for (genvar i = 0; i < NUM_CHAN; i++) begin : gen_steer
    assign lanes[i].push      = valid_q & (chan_q == chan_idx_t'(i));
    assign lanes[i].push_data = data_q;
  end

endmodule : ingress_steer

// ==== lane_fifo.sv ====
// circular buffer of LANE_DEPTH words for one channel
// a push to a full lane is dropped unless the head pops on the same edge
// overflow_o is sticky until flush_i and flush wins over push and pop

`timescale 1ns/1ps

module lane_fifo (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  lane_if.queue  lane,
  output logic   overflow_o
);
  import conc_cfg_pkg::*;
  import conc_msg_pkg::*;

  // storage and pointers
  payload_t             mem [LANE_DEPTH];
  logic     [PTR_W-1:0] wr_ptr_q;
  logic     [PTR_W-1:0] rd_ptr_q;
  fill_cnt_t            cnt_q;

  logic full;
  logic empty;
  logic pop;
  logic push_ok;
  logic drop;

  assign full  = (cnt_q == fill_cnt_t'(LANE_DEPTH));
  assign empty = (cnt_q == '0);

  // gnt only comes with req but empty is checked anyway
  assign pop     = lane.gnt & ~empty;
  // a pop on the same edge frees the slot for a push to a full lane
  assign push_ok = lane.push & (~full | pop);
  assign drop    = lane.push & full & ~pop;

  // toward the arbiter
  assign lane.req  = ~empty;
  assign lane.head = mem[rd_ptr_q];

  ////////////////////////////////////////////////////////////////////////////
  // control state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      overflow_o <= 1'b0;
    end else if (flush_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      overflow_o <= 1'b0;
    end else begin
      // pointers wrap at LANE_DEPTH
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(LANE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(LANE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // count moves only when exactly one side is active
      if (push_ok && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push_ok) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // sticky until the next flush
      if (drop) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push_ok && !flush_i) begin
      mem[wr_ptr_q] <= lane.push_data;
    end
  end

endmodule : lane_fifo

// ==== lane_if.sv ====
// one lane between ingress, its FIFO and the arbiter
// push has no back-pressure and gnt is only valid while req is high

`timescale 1ns/1ps

interface lane_if;
  import conc_msg_pkg::*;

  // one-cycle write strobe from ingress
  logic     push;
  payload_t push_data;
  // lane holds at least one word
  logic     req;
  // word at the FIFO head
  payload_t head;
  // pop the head on this edge
  logic     gnt;

  modport steer (output push, output push_data);
  modport queue (input push, input push_data, input gnt, output req, output head);
  modport arb   (input req, input head, output gnt);

endinterface : lane_if

// ==== msg_concentrator.f ====
conc_cfg_pkg.sv
conc_msg_pkg.sv
lane_if.sv
ingress_steer.sv
lane_fifo.sv
rr_arb_tree.sv
msg_concentrator.sv
msg_concentrator_asserts.sv
msg_concentrator_tb.sv

// ==== msg_concentrator.sv ====
// merges NUM_CHAN input channels onto one valid/ready output stream
// input is a strobe without back-pressure and full lanes drop new words
// a word reaches out_valid_o two edges after its input edge at the earliest

`timescale 1ns/1ps

module msg_concentrator (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  // input strobe side
  input  logic                                in_valid_i,
  input  conc_msg_pkg::chan_idx_t             in_chan_i,
  input  conc_msg_pkg::payload_t              in_data_i,
  // output stream side
  input  logic                                out_ready_i,
  output logic                                out_valid_o,
  output conc_msg_pkg::payload_t              out_data_o,
  output conc_msg_pkg::chan_idx_t             out_chan_o,
  // sticky per-lane drop flags
  output logic [conc_cfg_pkg::NUM_CHAN-1:0]   overflow_o
);
  import conc_cfg_pkg::*;

  // one bundle per lane
  lane_if lanes [NUM_CHAN] ();

  ingress_steer ingress_steer_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .in_valid_i (in_valid_i),
    .in_chan_i  (in_chan_i),
    .in_data_i  (in_data_i),
    .lanes      (lanes)
  );

  for (genvar i = 0; i < NUM_CHAN; i++) begin : gen_lanes
    lane_fifo lane_fifo_inst (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .lane       (lanes[i]),
      .overflow_o (overflow_o[i])
    );
  end

  // output ready is the arbiter grant and the arbiter request is output valid
  rr_arb_tree #(
    .NumIn (NUM_CHAN)
  ) rr_arb_tree_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .lanes   (lanes),
    .gnt_i   (out_ready_i),
    .req_o   (out_valid_o),
    .data_o  (out_data_o),
    .idx_o   (out_chan_o)
  );

endmodule : msg_concentrator

// ==== msg_concentrator_asserts.sv ====
// concurrent checks on the concentrator outputs, attached by bind
// the lane request wiring in the bind covers exactly four lanes
// fail_cnt counts failed checks for the testbench summary

`timescale 1ns/1ps

module msg_concentrator_asserts (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic                              flush_i,
  input logic                              out_ready_i,
  input logic                              out_valid_i,
  input conc_msg_pkg::payload_t            out_data_i,
  input conc_msg_pkg::chan_idx_t           out_chan_i,
  input logic [conc_cfg_pkg::NUM_CHAN-1:0] overflow_i,
  input logic [conc_cfg_pkg::NUM_CHAN-1:0] lane_req_i
);

  int unsigned fail_cnt = 0;

  // nothing offered while reset is held
  reset_quiet_a: assert property (@(posedge clk_i) !rst_ni |-> !out_valid_i)
    else begin
      $error("out_valid_o high during reset");
      fail_cnt++;
    end

  // flush empties every lane by the next cycle
  flush_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !out_valid_i)
    else begin
      $error("out_valid_o high in the cycle after flush");
      fail_cnt++;
    end

  // lock-in keeps the offered word stable until it is taken
  stall_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i && !out_ready_i && !flush_i |=>
      out_valid_i && $stable(out_chan_i) && $stable(out_data_i))
    else begin
      $error("offered word changed during a stall");
      fail_cnt++;
    end

  // valid follows lane occupancy
  valid_match_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i == (|lane_req_i))
    else begin
      $error("out_valid_o does not match lane occupancy");
      fail_cnt++;
    end

  // overflow bits are sticky outside flush
  ovf_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !flush_i |=> ((~overflow_i & $past(overflow_i)) == '0))
    else begin
      $error("overflow_o bit fell without flush");
      fail_cnt++;
    end

endmodule : msg_concentrator_asserts

bind msg_concentrator msg_concentrator_asserts asserts_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .flush_i     (flush_i),
  .out_ready_i (out_ready_i),
  .out_valid_i (out_valid_o),
  .out_data_i  (out_data_o),
  .out_chan_i  (out_chan_o),
  .overflow_i  (overflow_o),
  .lane_req_i  ({lanes[3].req, lanes[2].req, lanes[1].req, lanes[0].req})
);

// ==== msg_concentrator_tb.sv ====
// testbench for msg_concentrator with one model queue per channel
// inputs change on the rising edge and all checks run on the falling edge
// the round-robin check assumes a power-of-two channel count

`timescale 1ns/1ps

module msg_concentrator_tb;
  import conc_cfg_pkg::*;
  import conc_msg_pkg::*;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                flush_i;
  logic                in_valid_i;
  chan_idx_t           in_chan_i;
  payload_t            in_data_i;
  logic                out_ready_i;
  logic                out_valid_o;
  payload_t            out_data_o;
  chan_idx_t           out_chan_o;
  logic [NUM_CHAN-1:0] overflow_o;

  // model of lane contents, drop flags and pointer
  payload_t            model_q [NUM_CHAN][$];
  logic [NUM_CHAN-1:0] model_ovf;
  chan_idx_t           rr_ptr;
  // word held in the ingress register
  logic                staged_valid;
  chan_idx_t           staged_chan;
  payload_t            staged_data;
  // offered word of a stalled cycle
  logic                stall_prev;
  chan_idx_t           stall_chan;
  payload_t            stall_data;

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned tests = 0;
  int unsigned err_mark = 0;
  int unsigned fail_mark = 0;
  int unsigned xfers = 0;
  int unsigned xfer_mark;
  logic [31:0] lcg_state = 32'h504d;

  msg_concentrator msg_concentrator_inst (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic close_test(input string name);
    int unsigned fails;
    fails = msg_concentrator_inst.asserts_inst.fail_cnt;
    $display("%s test: %0d errors, %0d assertion failures", name, errors - err_mark,
             fails - fail_mark);
    err_mark  = errors;
    fail_mark = fails;
    tests++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model, one step per falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    logic any_busy;
    logic all_busy;
    any_busy = 1'b0;
    all_busy = 1'b1;
    for (int i = 0; i < NUM_CHAN; i++) begin
      any_busy |= (model_q[i].size() != 0);
      all_busy &= (model_q[i].size() != 0);
    end
    if (!rst_ni) begin
      for (int i = 0; i < NUM_CHAN; i++) model_q[i].delete();
      model_ovf    = '0;
      rr_ptr       = '0;
      staged_valid = 1'b0;
      stall_prev   = 1'b0;
    end else begin
      compare_value("out_valid_o", any_busy, out_valid_o);
      compare_value("overflow_o", model_ovf, overflow_o);
      // a stalled word must still be on offer
      if (stall_prev) begin
        compare_value("out_chan_o", stall_chan, out_chan_o);
        compare_value("out_data_o", stall_data, out_data_o);
      end else if (all_busy && out_valid_o) begin
        // every lane requesting means the pointer picks
        compare_value("out_chan_o", rr_ptr, out_chan_o);
      end
      if (flush_i) begin
        // flush beats push and pop, ingress word lost too
        for (int i = 0; i < NUM_CHAN; i++) model_q[i].delete();
        model_ovf    = '0;
        rr_ptr       = '0;
        staged_valid = 1'b0;
      end else begin
        // transfer on the coming edge
        if (out_valid_o && out_ready_i) begin
          if (model_q[out_chan_o].size() == 0) begin
            errors++;
            $display("word offered on channel %0d with nothing pending", out_chan_o);
          end else begin
            compare_value("out_data_o", model_q[out_chan_o].pop_front(), out_data_o);
          end
          rr_ptr = (rr_ptr == chan_idx_t'(NUM_CHAN - 1)) ? '0 : rr_ptr + 1'b1;
          xfers++;
        end
        // push after pop so a same-edge pop frees the slot
        if (staged_valid) begin
          if (model_q[staged_chan].size() < LANE_DEPTH) begin
            model_q[staged_chan].push_back(staged_data);
          end else begin
            model_ovf[staged_chan] = 1'b1;
          end
        end
        staged_valid = in_valid_i;
        staged_chan  = in_chan_i;
        staged_data  = in_data_i;
      end
      stall_prev = out_valid_o & ~out_ready_i & ~flush_i;
      stall_chan = out_chan_o;
      stall_data = out_data_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input logic valid, input chan_idx_t chan,
                             input payload_t data, input logic ready);
    @(posedge clk_i);
    in_valid_i  <= valid;
    in_chan_i   <= chan;
    in_data_i   <= data;
    out_ready_i <= ready;
    flush_i     <= 1'b0;
  endtask

  task automatic pulse_flush();
    @(posedge clk_i);
    flush_i     <= 1'b1;
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b0;
    drive_cycle(1'b0, '0, '0, 1'b0);
  endtask

  // two idle cycles cover the input to lane latency
  task automatic drain_lanes();
    int unsigned n;
    n = 0;
    drive_cycle(1'b0, '0, '0, 1'b1);
    drive_cycle(1'b0, '0, '0, 1'b1);
    do begin
      @(negedge clk_i);
      n++;
    end while (out_valid_o && n < 64);
    if (out_valid_o) begin
      errors++;
      $display("timeout: lanes still hold words after 64 cycles");
    end
  endtask

  task automatic random_traffic(input int unsigned cycles, input logic toggle_ready);
    logic [31:0] r;
    for (int unsigned n = 0; n < cycles; n++) begin
      r = lcg_next();
      drive_cycle(r[27], chan_idx_t'(r[25:24]), r[31:16], toggle_ready ? r[22] : 1'b1);
    end
  endtask

  // two words per lane under stall, then a full rotation from channel 0
  task automatic round_robin_burst();
    logic [31:0] r;
    for (int unsigned n = 0; n < 2 * NUM_CHAN; n++) begin
      r = lcg_next();
      drive_cycle(1'b1, chan_idx_t'(n % NUM_CHAN), r[31:16], 1'b0);
    end
    drive_cycle(1'b0, '0, '0, 1'b0);
    // k-th transfer after the flush comes from channel k mod NUM_CHAN
    for (int unsigned k = 0; k < 2 * NUM_CHAN; k++) begin
      drive_cycle(1'b0, '0, '0, 1'b1);
      @(negedge clk_i);
      compare_value("out_valid_o", 1'b1, out_valid_o);
      compare_value("out_chan_o", k % NUM_CHAN, out_chan_o);
    end
    drain_lanes();
  endtask

  initial begin
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_chan_i   = '0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    pulse_flush();
    random_traffic(40, 1'b0);
    drain_lanes();
    close_test("order");

    pulse_flush();
    round_robin_burst();
    close_test("round robin");

    pulse_flush();
    random_traffic(60, 1'b1);
    drain_lanes();
    close_test("lock-in");

    // six words into one four-deep lane
    pulse_flush();
    for (int n = 0; n < 6; n++) drive_cycle(1'b1, 2'd2, payload_t'(16'h2200 + n), 1'b0);
    drive_cycle(1'b0, '0, '0, 1'b0);
    drive_cycle(1'b0, '0, '0, 1'b0);
    @(negedge clk_i);
    compare_value("overflow_o", 4'b0100, overflow_o);
    xfer_mark = xfers;
    drain_lanes();
    compare_value("transfer count", 4, xfers - xfer_mark);
    close_test("overflow");

    // loaded lanes with one overflow, then flush
    for (int n = 0; n < 5; n++) drive_cycle(1'b1, 2'd1, payload_t'(16'h1100 + n), 1'b0);
    drive_cycle(1'b1, 2'd3, 16'h3300, 1'b0);
    pulse_flush();
    drive_cycle(1'b0, '0, '0, 1'b0);
    @(negedge clk_i);
    compare_value("out_valid_o", 1'b0, out_valid_o);
    compare_value("overflow_o", '0, overflow_o);
    xfer_mark = xfers;
    drive_cycle(1'b1, 2'd3, 16'h3301, 1'b1);
    drain_lanes();
    compare_value("transfer count", 1, xfers - xfer_mark);
    pulse_flush();
    round_robin_burst();
    close_test("flush");

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, msg_concentrator_inst.asserts_inst.fail_cnt);
    if (errors == 0 && msg_concentrator_inst.asserts_inst.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : msg_concentrator_tb

// ==== rr_arb_tree.sv ====
// logarithmic round-robin arbiter over NumIn lanes with lock-in
// needs NumIn >= 2 and lanes must keep req high until granted
// with all lanes requesting the winner equals the pointer only for power-of-two NumIn

`timescale 1ns/1ps

module rr_arb_tree #(
  parameter int unsigned NumIn = conc_cfg_pkg::NUM_CHAN
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  lane_if.arb                     lanes [NumIn],
  input  logic                    gnt_i,
  output logic                    req_o,
  output conc_msg_pkg::payload_t  data_o,
  output conc_msg_pkg::chan_idx_t idx_o
);
  import conc_msg_pkg::*;

  localparam int unsigned NumLevels = $clog2(NumIn);
  localparam int unsigned NumNodes  = 2**NumLevels - 1;

  // flattened lane side
  logic     [NumIn-1:0] req_in;
  logic     [NumIn-1:0] gnt_out;
  payload_t [NumIn-1:0] data_in;

  // lock and pointer state
  logic                 lock_q;
  logic     [NumIn-1:0] req_q;
  logic     [NumIn-1:0] req_d;
  logic [NumLevels-1:0] rr_q;
  logic [NumLevels-1:0] rr_d;

  // tree nodes with node 0 at the root
  logic     [NumNodes-1:0][NumLevels-1:0] index_nodes;
  payload_t [NumNodes-1:0]                data_nodes;
  logic     [NumNodes-1:0]                gnt_nodes;
  logic     [NumNodes-1:0]                req_nodes;

  for (genvar i = 0; i < NumIn; i++) begin : gen_lane_io
    assign req_in[i]     = lanes[i].req;
    assign data_in[i]    = lanes[i].head;
    assign lanes[i].gnt  = gnt_out[i];
  end

  ////////////////////////////////////////////////////////////////////////////
  // lock-in and round-robin pointer
  ////////////////////////////////////////////////////////////////////////////

  // while stalled the tree sees the request vector of the offered decision
  assign req_d = lock_q ? req_q : req_in;

  // advance by one per transfer and wrap at NumIn
  assign rr_d = (req_o && gnt_i) ?
                ((rr_q == NumLevels'(NumIn - 1)) ? '0 : rr_q + 1'b1) : rr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
      req_q  <= '0;
      rr_q   <= '0;
    end else if (flush_i) begin
      lock_q <= 1'b0;
      req_q  <= '0;
      rr_q   <= '0;
    end else begin
      // offered but not taken
      lock_q <= req_o & ~gnt_i;
      req_q  <= req_d;
      rr_q   <= rr_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // select tree
  ////////////////////////////////////////////////////////////////////////////

  assign req_o        = req_nodes[0];
  assign data_o       = data_nodes[0];
  assign idx_o        = chan_idx_t'(index_nodes[0]);
  assign gnt_nodes[0] = gnt_i;

  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar l = 0; l < 2**level; l++) begin : gen_nodes
      // this node and its left child
      localparam int unsigned Idx0 = 2**level - 1 + l;
      localparam int unsigned Idx1 = 2**(level + 1) - 1 + l * 2;

      if (level == NumLevels - 1) begin : gen_leaf
        if (l * 2 < NumIn - 1) begin : gen_pair
          logic sel;
          // take the right lane if the left is idle or the pointer bit says so
          assign sel = ~req_d[l*2] | (req_d[l*2+1] & rr_q[NumLevels-1-level]);
          assign req_nodes[Idx0]   = req_d[l*2] | req_d[l*2+1];
          assign index_nodes[Idx0] = NumLevels'(sel);
          assign data_nodes[Idx0]  = sel ? data_in[l*2+1] : data_in[l*2];
          assign gnt_out[l*2]      = gnt_nodes[Idx0] & req_d[l*2] & ~sel;
          assign gnt_out[l*2+1]    = gnt_nodes[Idx0] & req_d[l*2+1] & sel;
        end else if (l * 2 == NumIn - 1) begin : gen_single
          // odd lane count leaves one lane without a partner
          assign req_nodes[Idx0]   = req_d[l*2];
          assign index_nodes[Idx0] = '0;
          assign data_nodes[Idx0]  = data_in[l*2];
          assign gnt_out[l*2]      = gnt_nodes[Idx0] & req_d[l*2];
        end else begin : gen_pruned
          assign req_nodes[Idx0]   = 1'b0;
          assign index_nodes[Idx0] = '0;
          assign data_nodes[Idx0]  = '0;
        end
      end else begin : gen_inner
        logic                 sel;
        logic [NumLevels-1:0] child_idx;
        assign sel = ~req_nodes[Idx1] | (req_nodes[Idx1+1] & rr_q[NumLevels-1-level]);
        assign child_idx = sel ? index_nodes[Idx1+1] : index_nodes[Idx1];
        // this level contributes one index bit above the child's bits
        assign index_nodes[Idx0] = NumLevels'({sel, child_idx[NumLevels-level-2:0]});
        assign req_nodes[Idx0]   = req_nodes[Idx1] | req_nodes[Idx1+1];
        assign data_nodes[Idx0]  = sel ? data_nodes[Idx1+1] : data_nodes[Idx1];
        // grant travels down the selected branch only
        assign gnt_nodes[Idx1]   = gnt_nodes[Idx0] & ~sel;
        assign gnt_nodes[Idx1+1] = gnt_nodes[Idx0] & sel;
      end
    end
  end

endmodule : rr_arb_tree
